/* source/scaler_pkg.sv */
`default_nettype none

package scaler_pkg;

    // scaler counters
    localparam int unsigned scal_width_c = 16;
    localparam logic [scal_width_c-1:0] scal_max_c = {scal_width_c{1'b1}};

    // register map, byte addresses in the 7-bit bus address
    localparam logic [6:0] gate_ctrl_addr_c = 7'h00;
    localparam logic [6:0] gate_en_addr_c = 7'h04;
    localparam logic [6:0] scaler_addr_base_c = 7'h10;
    // address bits that tell control from enable
    localparam logic [6:0] reg_sel_mask_c = gate_ctrl_addr_c ^ gate_en_addr_c;

    // gate select codes, 1 to 6 pick gp_gate_i[0] to gp_gate_i[5]
    localparam logic [2:0] gate_sel_off_c = 3'd0;
    localparam logic [2:0] gate_sel_pps_c = 3'd7;

    // bus-side state machine
    localparam int unsigned fsm_bits_c = 3;
    localparam logic [fsm_bits_c-1:0] st_idle_c = 3'd0;
    localparam logic [fsm_bits_c-1:0] st_cycle_c = 3'd1;
    localparam logic [fsm_bits_c-1:0] st_wait_busy_c = 3'd2;
    localparam logic [fsm_bits_c-1:0] st_ack_c = 3'd3;
    localparam logic [fsm_bits_c-1:0] st_scaler_c = 3'd4;

    // control word: raw on the bus side, decoded in sysclk
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [15:0] gatelen;
            logic [12:0] pad;
            logic [2:0]  sel;
        } fields;
    } gate_ctrl_u;

endpackage

`default_nettype wire

/* source/flag_sync.sv */
`default_nettype none

module flag_sync (
    input  wire  clk_a_i,
    input  wire  clk_b_i,
    input  wire  in_a_i,
    output logic out_b_o,
    output logic busy_a_o
);

    // source side toggle, flips once per request
    logic       toggle_a = 1'b0;
    // destination synchronizer plus one stage for edge detect
    logic [2:0] sync_b = 3'b000;
    // acknowledge path back into clk_a
    logic [1:0] sync_a = 2'b00;

    always_ff @(posedge clk_a_i) begin
        if (in_a_i) begin
            toggle_a <= ~toggle_a;
        end
    end

    always_ff @(posedge clk_b_i) begin
        sync_b <= {sync_b[1:0], toggle_a};
    end

    always_ff @(posedge clk_a_i) begin
        // return the settled toggle, so the pulse in clk_b is already done
        sync_a <= {sync_a[0], sync_b[2]};
    end

    assign out_b_o = sync_b[2] ^ sync_b[1];

    // busy until the toggle has made the round trip
    assign busy_a_o = toggle_a ^ sync_a[1];

    // a second request while busy would be lost in the crossing
    assert property (@(posedge clk_a_i) busy_a_o |-> !in_a_i)
        else $error("flag_sync: request while crossing is busy");

endmodule

`default_nettype wire

/* source/trigger_scaler_bank.sv */
`default_nettype none

module trigger_scaler_bank (
    input  wire                                  sysclk_i,
    input  wire                                  pps_i,
    input  wire  [1:0]                           mie_i,
    input  wire  [1:0]                           lf_i,
    input  wire                                  aux_i,
    input  wire                                  levelthree_i,
    output logic                                 captured_o,
    output logic [scaler_pkg::scal_width_c-1:0]  mie0_hold_o,
    output logic [scaler_pkg::scal_width_c-1:0]  mie1_hold_o,
    output logic [scaler_pkg::scal_width_c-1:0]  lf0_hold_o,
    output logic [scaler_pkg::scal_width_c-1:0]  lf1_hold_o,
    output logic [scaler_pkg::scal_width_c-1:0]  aux_hold_o,
    output logic [scaler_pkg::scal_width_c-1:0]  l3_hold_o
);

    localparam int unsigned n_scal_c = 6;

    // order: mie0, mie1, lf0, lf1, aux, levelthree
    logic [n_scal_c-1:0] strobe;

    logic [scaler_pkg::scal_width_c-1:0] working [n_scal_c] = '{default: '0};
    logic [scaler_pkg::scal_width_c-1:0] holding [n_scal_c] = '{default: '0};

    logic captured = 1'b0;

    assign strobe = {levelthree_i, aux_i, lf_i, mie_i};

    for (genvar i = 0; i < n_scal_c; i++) begin : g_scal

        always_ff @(posedge sysclk_i) begin
            // a strobe in the pps cycle falls between the two frames
            if (pps_i) begin
                working[i] <= '0;
            end else if (strobe[i] && working[i] != scaler_pkg::scal_max_c) begin
                working[i] <= working[i] + 1'b1;
            end

            if (pps_i) begin
                holding[i] <= working[i];
            end
        end

        // only pps may bring a count down
        assert property (@(posedge sysclk_i) !pps_i |=> working[i] >= $past(working[i]))
            else $error("trigger_scaler_bank: counter %0d went backwards", i);

    end

    // holding values settle on the pps edge, flag them one cycle later
    always_ff @(posedge sysclk_i) begin
        captured <= pps_i;
    end

    assign captured_o  = captured;
    assign mie0_hold_o = holding[0];
    assign mie1_hold_o = holding[1];
    assign lf0_hold_o  = holding[2];
    assign lf1_hold_o  = holding[3];
    assign aux_hold_o  = holding[4];
    assign l3_hold_o   = holding[5];

endmodule

`default_nettype wire

/* source/gate_generator.sv */
`default_nettype none

module gate_generator (
    input  wire         sysclk_i,
    input  wire         pps_i,
    input  wire  [5:0]  gp_gate_i,
    input  wire         access_i,
    input  wire         write_i,
    input  wire         enable_sel_i,
    input  wire  [31:0] wr_data_i,
    output logic [31:0] ctrl_rd_o,
    output logic [31:0] gate_en_o,
    output logic        gate_o
);

    scaler_pkg::gate_ctrl_u wr_ctrl;
    scaler_pkg::gate_ctrl_u rd_ctrl;

    // configuration loaded from the bus through the access crossing
    logic [2:0]  gate_sel = scaler_pkg::gate_sel_off_c;
    logic [15:0] gatelen = '0;
    logic [31:0] gate_enable = '0;

    logic        pps_gate = 1'b0;
    logic [15:0] pps_gate_cnt = '0;
    logic [5:0]  gp_rereg = '0;
    logic [7:0]  gate_in;
    logic        gate = 1'b0;

    assign wr_ctrl.raw = wr_data_i;

    always_ff @(posedge sysclk_i) begin
        if (access_i && write_i && !enable_sel_i) begin
            gate_sel <= wr_ctrl.fields.sel;
            gatelen  <= wr_ctrl.fields.gatelen;
        end
        if (access_i && write_i && enable_sel_i) begin
            gate_enable <= wr_ctrl.raw;
        end
    end

    // pps gate stays high for gatelen + 1 cycles
    always_ff @(posedge sysclk_i) begin
        if (gate_sel == scaler_pkg::gate_sel_pps_c && pps_i) begin
            pps_gate <= 1'b1;
        end else if (pps_gate_cnt == gatelen) begin
            pps_gate <= 1'b0;
        end

        if (!pps_gate) begin
            pps_gate_cnt <= '0;
        end else begin
            pps_gate_cnt <= pps_gate_cnt + 1'b1;
        end
    end

    // select codes map directly onto bit positions, code 0 picks the low constant
    assign gate_in = {pps_gate, gp_rereg, 1'b0};

    always_ff @(posedge sysclk_i) begin
        gp_rereg <= gp_gate_i;
        gate     <= gate_in[gate_sel];
    end

    always_comb begin
        rd_ctrl.fields.gatelen = gatelen;
        rd_ctrl.fields.pad     = '0;
        rd_ctrl.fields.sel     = gate_sel;
    end

    assign ctrl_rd_o = rd_ctrl.raw;
    assign gate_en_o = gate_enable;
    assign gate_o    = gate;

    // pps gate must only open in pps mode
    assert property (@(posedge sysclk_i)
        $rose(pps_gate) |-> $past(gate_sel) == scaler_pkg::gate_sel_pps_c)
        else $error("gate_generator: pps gate opened with select %0d", $past(gate_sel));

endmodule

`default_nettype wire

/* source/scaler_wb_port.sv */
`default_nettype none

module scaler_wb_port (
    input  wire                                 wb_clk_i,
    input  wire                                 wb_rst_i,
    input  wire                                 wb_cyc_i,
    input  wire                                 wb_stb_i,
    input  wire                                 wb_we_i,
    input  wire  [6:0]                          wb_adr_i,
    input  wire  [31:0]                         wb_dat_i,
    output logic                                wb_ack_o,
    output logic [31:0]                         wb_dat_o,
    output logic                                access_o,
    input  wire                                 access_busy_i,
    output logic                                write_o,
    output logic                                enable_sel_o,
    input  wire                                 captured_i,
    input  wire  [scaler_pkg::scal_width_c-1:0] mie0_hold_i,
    input  wire  [scaler_pkg::scal_width_c-1:0] mie1_hold_i,
    input  wire  [scaler_pkg::scal_width_c-1:0] lf0_hold_i,
    input  wire  [scaler_pkg::scal_width_c-1:0] lf1_hold_i,
    input  wire  [scaler_pkg::scal_width_c-1:0] aux_hold_i,
    input  wire  [scaler_pkg::scal_width_c-1:0] l3_hold_i,
    input  wire  [31:0]                         ctrl_rd_i,
    input  wire  [31:0]                         gate_en_i
);

    logic [scaler_pkg::fsm_bits_c-1:0] state = scaler_pkg::st_idle_c;

    logic        bus_req;
    logic        is_scaler;
    logic        is_enable;

    logic        access_write = 1'b0;
    logic        enable_sel = 1'b0;
    logic [31:0] dat_holding = '0;

    // bus-side copies of the counts, refreshed once per pps
    logic [scaler_pkg::scal_width_c-1:0] mie0_scal = '0;
    logic [scaler_pkg::scal_width_c-1:0] mie1_scal = '0;
    logic [scaler_pkg::scal_width_c-1:0] lf0_scal = '0;
    logic [scaler_pkg::scal_width_c-1:0] lf1_scal = '0;
    logic [scaler_pkg::scal_width_c-1:0] aux_scal = '0;
    logic [scaler_pkg::scal_width_c-1:0] l3_scal = '0;

    logic [31:0] scaler_word;

    assign bus_req   = wb_cyc_i && wb_stb_i;
    assign is_scaler = |(wb_adr_i & scaler_pkg::scaler_addr_base_c);
    assign is_enable = |((wb_adr_i ^ scaler_pkg::gate_ctrl_addr_c) & scaler_pkg::reg_sel_mask_c);

    // holding registers are stable until the next pps
    always_ff @(posedge wb_clk_i) begin
        if (captured_i) begin
            mie0_scal <= mie0_hold_i;
            mie1_scal <= mie1_hold_i;
            lf0_scal  <= lf0_hold_i;
            lf1_scal  <= lf1_hold_i;
            aux_scal  <= aux_hold_i;
            l3_scal   <= l3_hold_i;
        end
    end

    always_comb begin
        case (wb_adr_i[3:2])
            2'd0: scaler_word = {mie1_scal, mie0_scal};
            2'd2: scaler_word = {l3_scal, aux_scal};
            // word 3 mirrors word 1
            default: scaler_word = {lf1_scal, lf0_scal};
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state <= scaler_pkg::st_idle_c;
        end else begin
            case (state)
                scaler_pkg::st_idle_c: begin
                    if (bus_req && is_scaler) begin
                        state <= scaler_pkg::st_scaler_c;
                    end else if (bus_req) begin
                        state <= scaler_pkg::st_cycle_c;
                    end
                end
                scaler_pkg::st_cycle_c: begin
                    state <= scaler_pkg::st_wait_busy_c;
                end
                scaler_pkg::st_wait_busy_c: begin
                    if (!access_busy_i) begin
                        state <= scaler_pkg::st_ack_c;
                    end
                end
                scaler_pkg::st_scaler_c: begin
                    state <= scaler_pkg::st_ack_c;
                end
                default: begin
                    state <= scaler_pkg::st_idle_c;
                end
            endcase
        end
    end

    // access type is latched with the request and held through the crossing
    always_ff @(posedge wb_clk_i) begin
        if (state == scaler_pkg::st_idle_c && bus_req) begin
            access_write <= wb_we_i;
            enable_sel   <= is_enable;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state == scaler_pkg::st_idle_c) begin
            dat_holding <= wb_dat_i;
        end else if (state == scaler_pkg::st_scaler_c) begin
            dat_holding <= scaler_word;
        end else if (state == scaler_pkg::st_wait_busy_c && !access_busy_i && !access_write) begin
            // sysclk side finished, its registers are quiet now
            dat_holding <= enable_sel ? gate_en_i : ctrl_rd_i;
        end
    end

    assign access_o     = (state == scaler_pkg::st_cycle_c);
    assign write_o      = access_write;
    assign enable_sel_o = enable_sel;
    assign wb_ack_o     = (state == scaler_pkg::st_ack_c);
    assign wb_dat_o     = dat_holding;

    assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) wb_ack_o |=> !wb_ack_o)
        else $error("scaler_wb_port: ack held for two cycles");

endmodule

`default_nettype wire

/* source/scaler_register_core.sv */
`default_nettype none

module scaler_register_core (
    input  wire         wb_clk_i,
    input  wire         wb_rst_i,
    input  wire         wb_cyc_i,
    input  wire         wb_stb_i,
    input  wire         wb_we_i,
    input  wire  [6:0]  wb_adr_i,
    input  wire  [31:0] wb_dat_i,
    // byte lanes ignored, all accesses are full words
    input  wire  [3:0]  wb_sel_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o,
    input  wire         sysclk_i,
    input  wire         pps_i,
    input  wire  [1:0]  mie_i,
    input  wire  [1:0]  lf_i,
    input  wire         aux_i,
    input  wire         levelthree_i,
    input  wire  [5:0]  gp_gate_i,
    output logic        gate_o,
    output logic [31:0] gate_en_o
);

    wire access_wb;
    wire access_sys;
    wire access_busy;
    wire access_write;
    wire enable_sel;
    wire captured_sys;
    wire captured_wb;

    wire [scaler_pkg::scal_width_c-1:0] mie0_hold;
    wire [scaler_pkg::scal_width_c-1:0] mie1_hold;
    wire [scaler_pkg::scal_width_c-1:0] lf0_hold;
    wire [scaler_pkg::scal_width_c-1:0] lf1_hold;
    wire [scaler_pkg::scal_width_c-1:0] aux_hold;
    wire [scaler_pkg::scal_width_c-1:0] l3_hold;

    wire [31:0] ctrl_rd;

    trigger_scaler_bank u_bank (
        .sysclk_i     (sysclk_i),
        .pps_i        (pps_i),
        .mie_i        (mie_i),
        .lf_i         (lf_i),
        .aux_i        (aux_i),
        .levelthree_i (levelthree_i),
        .captured_o   (captured_sys),
        .mie0_hold_o  (mie0_hold),
        .mie1_hold_o  (mie1_hold),
        .lf0_hold_o   (lf0_hold),
        .lf1_hold_o   (lf1_hold),
        .aux_hold_o   (aux_hold),
        .l3_hold_o    (l3_hold)
    );

    // write data comes straight from the port holding register
    gate_generator u_gate (
        .sysclk_i     (sysclk_i),
        .pps_i        (pps_i),
        .gp_gate_i    (gp_gate_i),
        .access_i     (access_sys),
        .write_i      (access_write),
        .enable_sel_i (enable_sel),
        .wr_data_i    (wb_dat_o),
        .ctrl_rd_o    (ctrl_rd),
        .gate_en_o    (gate_en_o),
        .gate_o       (gate_o)
    );

    scaler_wb_port u_port (
        .wb_clk_i      (wb_clk_i),
        .wb_rst_i      (wb_rst_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_o      (wb_ack_o),
        .wb_dat_o      (wb_dat_o),
        .access_o      (access_wb),
        .access_busy_i (access_busy),
        .write_o       (access_write),
        .enable_sel_o  (enable_sel),
        .captured_i    (captured_wb),
        .mie0_hold_i   (mie0_hold),
        .mie1_hold_i   (mie1_hold),
        .lf0_hold_i    (lf0_hold),
        .lf1_hold_i    (lf1_hold),
        .aux_hold_i    (aux_hold),
        .l3_hold_i     (l3_hold),
        .ctrl_rd_i     (ctrl_rd),
        .gate_en_i     (gate_en_o)
    );

    flag_sync u_access_sync (
        .clk_a_i  (wb_clk_i),
        .clk_b_i  (sysclk_i),
        .in_a_i   (access_wb),
        .out_b_o  (access_sys),
        .busy_a_o (access_busy)
    );

    // one capture per second, busy never matters here
    flag_sync u_capture_sync (
        .clk_a_i  (sysclk_i),
        .clk_b_i  (wb_clk_i),
        .in_a_i   (captured_sys),
        .out_b_o  (captured_wb),
        .busy_a_o ()
    );

endmodule

`default_nettype wire

/* test/tb_scaler_register_core.sv */
`default_nettype none

module tb_scaler_register_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_rows_c = 25;
    localparam int cycle_limit_c = 70000 + 400 * n_rows_c;
    localparam int gate_span_c = 40;
    // capture crossing settles in about five bus cycles
    localparam int capture_wait_c = 8;

    localparam logic [2:0] op_idle_c = 3'd0;
    localparam logic [2:0] op_write_c = 3'd1;
    localparam logic [2:0] op_read_c = 3'd2;
    localparam logic [2:0] op_count_c = 3'd3;
    localparam logic [2:0] op_gate_c = 3'd4;

    // cnt holds mie0, mie1, lf0, lf1, aux and levelthree in that order
    typedef struct packed {
        logic [2:0]       op;
        logic [6:0]       addr;
        logic [31:0]      data;
        logic [5:0][16:0] cnt;
        logic [31:0]      exp;
    } row_t;

    logic        wb_clk_i;
    logic        wb_rst_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [6:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic        wb_ack_o;
    logic [31:0] wb_dat_o;
    logic        sysclk_i;
    logic        pps_i;
    logic [1:0]  mie_i;
    logic [1:0]  lf_i;
    logic        aux_i;
    logic        levelthree_i;
    logic [5:0]  gp_gate_i;
    logic        gate_o;
    logic [31:0] gate_en_o;

    row_t rows [n_rows_c];
    int   errors = 0;
    int   row_errors = 0;
    int   rows_failed = 0;
    int   cycles = 0;

    scaler_register_core u_scaler_register_core (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o),
        .sysclk_i     (sysclk_i),
        .pps_i        (pps_i),
        .mie_i        (mie_i),
        .lf_i         (lf_i),
        .aux_i        (aux_i),
        .levelthree_i (levelthree_i),
        .gp_gate_i    (gp_gate_i),
        .gate_o       (gate_o),
        .gate_en_o    (gate_en_o)
    );

    initial begin
        sysclk_i = 1'b0;
        forever #10 sysclk_i = ~sysclk_i;
    end

    initial begin
        wb_clk_i = 1'b0;
        forever #15 wb_clk_i = ~wb_clk_i;
    end

    always @(posedge sysclk_i) begin
        cycles++;
        if (cycles >= cycle_limit_c) begin
            $display("timeout: run still busy after %0d sysclk cycles", cycle_limit_c);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic note_error(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        errors++;
        row_errors++;
    endtask

    function automatic logic [15:0] clip(input logic [16:0] n);
        if (n > 17'h0ffff) begin
            return 16'hffff;
        end else begin
            return n[15:0];
        end
    endfunction

    function automatic string op_name(input logic [2:0] op);
        case (op)
            op_idle_c:  return "idle";
            op_write_c: return "write";
            op_read_c:  return "read";
            op_count_c: return "count";
            default:    return "gate";
        endcase
    endfunction

    // one full Wishbone cycle held until ack
    task automatic bus_cycle(input logic we, input logic [6:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdat);
        @(posedge wb_clk_i);
        #2;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        do begin
            @(posedge wb_clk_i);
            #2;
        end while (!wb_ack_o);
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_dat_i = '0;
    endtask

    task automatic fill_table();
        logic [31:0] ctrl;
        logic [31:0] en;
        logic [15:0] len;
        rows = '{default: '0};
        for (int k = 0; k < 4; k++) begin
            rows[1 + k].op   = op_read_c;
            rows[1 + k].addr = scaler_pkg::scaler_addr_base_c + 7'(4 * k);
        end
        rows[5].op   = op_read_c;
        rows[5].addr = scaler_pkg::gate_ctrl_addr_c;
        rows[6].op   = op_read_c;
        rows[6].addr = scaler_pkg::gate_en_addr_c;
        // sel left at off so the gate stays quiet
        ctrl = $urandom & 32'hffff_fff8;
        en   = $urandom;
        rows[7]  = '{op_write_c, scaler_pkg::gate_ctrl_addr_c, ctrl, '0, '0};
        rows[8]  = '{op_read_c, scaler_pkg::gate_ctrl_addr_c, '0, '0, ctrl & 32'hffff_0007};
        rows[9]  = '{op_write_c, scaler_pkg::gate_en_addr_c, en, '0, '0};
        rows[10] = '{op_read_c, scaler_pkg::gate_en_addr_c, '0, '0, en};
        rows[11] = '{op_idle_c, '0, '0, '0, en};
        for (int r = 12; r < 16; r++) begin
            rows[r].op = op_count_c;
            for (int i = 0; i < 6; i++) begin
                rows[r].cnt[i] = 17'($urandom % 60);
            end
        end
        // aux runs past the 16-bit range
        rows[15].cnt[4] = 17'd65600;
        for (int s = 1; s <= 6; s++) begin
            rows[15 + s].op   = op_gate_c;
            rows[15 + s].data = ($urandom & 32'hffff_fff8) | 32'(s);
        end
        rows[22].op   = op_gate_c;
        rows[22].data = $urandom & 32'hffff_fff8;
        len = 16'(1 + $urandom % 40);
        rows[23] = '{op_gate_c, '0, {len, 13'h0, 3'd7}, '0, 32'(len) + 1};
        rows[24] = '{op_gate_c, '0, {16'h0, 13'h0, 3'd7}, '0, 32'd1};
    endtask

    task automatic run_idle_row(input row_t row);
        repeat (gate_span_c) begin
            @(posedge sysclk_i);
            #2;
            if (gate_o !== 1'b0) note_error("gate_o high while idle");
            if (gate_en_o !== row.exp) begin
                note_error($sformatf("gate_en_o %08h, expected %08h", gate_en_o, row.exp));
            end
        end
    endtask

    task automatic run_count_row(input row_t row);
        int          window;
        logic [31:0] got;
        logic [31:0] want [4];
        window = 0;
        for (int i = 0; i < 6; i++) begin
            if (row.cnt[i] > window) window = row.cnt[i];
        end
        window += 16;
        @(posedge sysclk_i);
        #2;
        pps_i = 1'b1;
        for (int c = 0; c < window; c++) begin
            @(posedge sysclk_i);
            #2;
            pps_i        = 1'b0;
            mie_i        = {c < row.cnt[1], c < row.cnt[0]};
            lf_i         = {c < row.cnt[3], c < row.cnt[2]};
            aux_i        = c < row.cnt[4];
            levelthree_i = c < row.cnt[5];
        end
        @(posedge sysclk_i);
        #2;
        {mie_i, lf_i, aux_i, levelthree_i} = '0;
        pps_i = 1'b1;
        @(posedge sysclk_i);
        #2;
        pps_i = 1'b0;
        repeat (capture_wait_c) @(posedge wb_clk_i);
        want[0] = {clip(row.cnt[1]), clip(row.cnt[0])};
        want[1] = {clip(row.cnt[3]), clip(row.cnt[2])};
        want[2] = {clip(row.cnt[5]), clip(row.cnt[4])};
        want[3] = want[1];
        for (int k = 0; k < 4; k++) begin
            bus_cycle(1'b0, scaler_pkg::scaler_addr_base_c + 7'(4 * k), '0, got);
            if (got !== want[k]) begin
                note_error($sformatf("scaler word %0d %08h, expected %08h", k, got, want[k]));
            end
        end
    endtask

    task automatic run_gate_row(input row_t row);
        logic [2:0]  sel;
        logic [5:0]  hist [gate_span_c];
        logic        want;
        logic [31:0] unused;
        sel = row.data[2:0];
        bus_cycle(1'b1, scaler_pkg::gate_ctrl_addr_c, row.data, unused);
        for (int j = 0; j < gate_span_c; j++) begin
            @(posedge sysclk_i);
            #2;
            // gp input reaches gate_o two edges after it is driven
            if (j >= 2) begin
                want = (sel == 3'd0) ? 1'b0 : hist[j - 2][sel - 1];
                if (gate_o !== want) begin
                    note_error($sformatf("sel %0d: gate_o %b, expected %b", sel, gate_o, want));
                end
            end
            hist[j]   = 6'($urandom);
            gp_gate_i = hist[j];
        end
    endtask

    task automatic run_pps_gate_row(input row_t row);
        int          len;
        int          high;
        logic        want;
        logic [31:0] unused;
        len = row.data[31:16];
        bus_cycle(1'b1, scaler_pkg::gate_ctrl_addr_c, row.data, unused);
        for (int p = 0; p < 2; p++) begin
            @(posedge sysclk_i);
            #2;
            pps_i = 1'b1;
            high  = 0;
            for (int j = 1; j <= len + 16; j++) begin
                @(posedge sysclk_i);
                #2;
                pps_i = 1'b0;
                want  = (j >= 2) && (j <= len + 2);
                if (gate_o !== want) begin
                    note_error($sformatf("pps gate cycle %0d: gate_o %b, expected %b",
                                         j, gate_o, want));
                end
                if (gate_o === 1'b1) high++;
            end
            if (high != row.exp) begin
                note_error($sformatf("pps gate high %0d cycles, expected %0d", high, row.exp));
            end
        end
    endtask

    initial begin
        logic [31:0] got;
        wb_rst_i     = 1'b1;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_sel_i     = 4'hf;
        pps_i        = 1'b0;
        mie_i        = '0;
        lf_i         = '0;
        aux_i        = 1'b0;
        levelthree_i = 1'b0;
        gp_gate_i    = '0;
        void'($urandom(32'h73e7_8613));
        fill_table();
        repeat (2) @(posedge wb_clk_i);
        #2;
        wb_rst_i = 1'b0;

        for (int r = 0; r < n_rows_c; r++) begin
            row_errors = 0;
            case (rows[r].op)
                op_idle_c: run_idle_row(rows[r]);
                op_write_c: begin
                    bus_cycle(1'b1, rows[r].addr, rows[r].data, got);
                    if (rows[r].addr == scaler_pkg::gate_en_addr_c &&
                        gate_en_o !== rows[r].data) begin
                        note_error($sformatf("gate_en_o %08h, expected %08h",
                                             gate_en_o, rows[r].data));
                    end
                end
                op_read_c: begin
                    bus_cycle(1'b0, rows[r].addr, '0, got);
                    if (got !== rows[r].exp) begin
                        note_error($sformatf("read %02h gave %08h, expected %08h",
                                             rows[r].addr, got, rows[r].exp));
                    end
                end
                op_count_c: run_count_row(rows[r]);
                default: begin
                    if (rows[r].data[2:0] == scaler_pkg::gate_sel_pps_c) begin
                        run_pps_gate_row(rows[r]);
                    end else begin
                        run_gate_row(rows[r]);
                    end
                end
            endcase
            if (row_errors == 0) begin
                $display("row %0d %s: ok", r, op_name(rows[r].op));
            end else begin
                rows_failed++;
                $display("row %0d %s: %0d errors", r, op_name(rows[r].op), row_errors);
            end
        end

        $display("rows run %0d, passed %0d, failed %0d, mismatches %0d",
                 n_rows_c, n_rows_c - rows_failed, rows_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
source/scaler_pkg.sv
source/flag_sync.sv
source/trigger_scaler_bank.sv
source/gate_generator.sv
source/scaler_wb_port.sv
source/scaler_register_core.sv
test/tb_scaler_register_core.sv
